/* rtl/cache_pkg.sv */
package cache_pkg;

   localparam int WORD_W   = 16;
   localparam int ADDR_W   = 16;
   localparam int TAG_W    = 5;
   localparam int INDEX_W  = 8;
   localparam int OFFSET_W = 2;

   localparam int NUM_LINES      = 256;
   localparam int WORDS_PER_LINE = 4;

   // backing memory, 64KB of byte space in 16-bit words
   localparam int MEM_WORDS    = 32768;
   localparam int BANK_DEPTH   = MEM_WORDS / WORDS_PER_LINE;
   localparam int BANK_ROW_W   = $clog2(BANK_DEPTH);
   localparam int MEM_READ_LAT = 2;   // accepted read to valid data
   localparam int BANK_BUSY    = 3;   // cycles a bank refuses after an access
   localparam int BUSY_CNT_W   = $clog2(BANK_BUSY + 1);
   localparam logic [WORD_W-1:0] MEM_INIT_KEY = 16'hA5A5;

   typedef logic [WORD_W-1:0]   word_t;
   typedef logic [ADDR_W-1:0]   addr_t;    // {tag, index, offset, byte}
   typedef logic [TAG_W-1:0]    tag_t;
   typedef logic [INDEX_W-1:0]  index_t;
   typedef logic [OFFSET_W-1:0] offset_t;  // word in line, also the bank

   typedef enum logic [3:0] {
      IDLE          = 4'h0,
      COMPARE_READ  = 4'h1,
      COMPARE_WRITE = 4'h2,
      WB_0          = 4'h3,
      WB_1          = 4'h4,
      WB_2          = 4'h5,
      WB_3          = 4'h6,
      ALLOC0        = 4'h7,  // fetch word 0
      ALLOC1        = 4'h8,  // fetch word 1
      ALLOC2        = 4'h9,  // fetch word 2, install word 0
      ALLOC3        = 4'hA,  // fetch word 3, install word 1
      ALLOC4        = 4'hB,  // install word 2
      COMMIT        = 4'hC,  // install word 3 and mark line valid
      RD_RETRY      = 4'hD,
      WR_RETRY      = 4'hE,
      ERROR         = 4'hF
   } ctrl_state_e;

   typedef struct packed {
      logic    en;
      logic    comp;
      logic    write;
      logic    valid_in;
      index_t  index;
      tag_t    tag;
      offset_t offset;
      word_t   wdata;
   } cache_req_t;

   typedef struct packed {
      logic  hit;
      logic  dirty;
      logic  valid;
      tag_t  tag;     // tag stored at the indexed line
      word_t rdata;
   } cache_rsp_t;

   typedef struct packed {
      logic  rd;
      logic  wr;
      addr_t addr;
      word_t wdata;
   } mem_req_t;

endpackage

/* rtl/banked_mem.sv */
`timescale 1ns/1ns
module banked_mem
   import cache_pkg::*;
(
   input  logic     clk,
   input  logic     arst_n,
   input  mem_req_t mem_req,
   output logic     mem_stall,
   output word_t    mem_rdata
);

   word_t                 bank_q   [WORDS_PER_LINE][BANK_DEPTH];
   logic [BUSY_CNT_W-1:0] busy_cnt [WORDS_PER_LINE];
   word_t                 rd_pipe  [MEM_READ_LAT];

   offset_t               bank_sel;
   logic [BANK_ROW_W-1:0] row;
   logic                  accept;

   // low word-address bits pick the bank, so a line spreads over all four
   assign bank_sel = mem_req.addr[1 +: OFFSET_W];
   assign row      = mem_req.addr[ADDR_W-1 -: BANK_ROW_W];

   assign mem_stall = (busy_cnt[bank_sel] != '0);
   assign accept    = (mem_req.rd | mem_req.wr) & ~mem_stall;

   // every word starts as its word address xor the key
   initial begin
      for (int r = 0; r < BANK_DEPTH; r++) begin
         for (int b = 0; b < WORDS_PER_LINE; b++) begin
            bank_q[b][r] = word_t'(r * WORDS_PER_LINE + b) ^ MEM_INIT_KEY;
         end
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int b = 0; b < WORDS_PER_LINE; b++) begin
            busy_cnt[b] <= '0;
         end
      end else begin
         for (int b = 0; b < WORDS_PER_LINE; b++) begin
            if (accept && bank_sel == offset_t'(b)) begin
               busy_cnt[b] <= BUSY_CNT_W'(BANK_BUSY);
            end else if (busy_cnt[b] != '0) begin
               busy_cnt[b] <= busy_cnt[b] - 1'b1;
            end
         end
      end
   end

   always @(posedge clk) begin
      if (accept && mem_req.wr) begin
         bank_q[bank_sel][row] <= mem_req.wdata;
      end
   end

   // fixed-latency read return, one read can issue every cycle
   always_ff @(posedge clk) begin
      if (accept && mem_req.rd) begin
         rd_pipe[0] <= bank_q[bank_sel][row];
      end
      for (int s = 1; s < MEM_READ_LAT; s++) begin
         rd_pipe[s] <= rd_pipe[s-1];
      end
   end

   assign mem_rdata = rd_pipe[MEM_READ_LAT-1];

endmodule

/* rtl/cache_store.sv */
`timescale 1ns/1ns
module cache_store
   import cache_pkg::*;
(
   input  logic       clk,
   input  logic       arst_n,
   input  cache_req_t cache_req,
   output cache_rsp_t cache_rsp
);

   logic    valid_q [NUM_LINES];
   logic    dirty_q [NUM_LINES];
   tag_t    tag_q   [NUM_LINES];
   word_t   data_q  [NUM_LINES][WORDS_PER_LINE];

   index_t  idx;
   offset_t off;
   logic    tag_match;
   logic    cmp_write;   // write hit, word update only
   logic    install;     // line fill from memory

   assign idx = cache_req.index;
   assign off = cache_req.offset;

   assign tag_match = (tag_q[idx] == cache_req.tag);

   // lookup is combinational, same cycle as the request
   assign cache_rsp.hit   = cache_req.en & tag_match;
   assign cache_rsp.dirty = dirty_q[idx];
   assign cache_rsp.valid = valid_q[idx];
   assign cache_rsp.tag   = tag_q[idx];
   assign cache_rsp.rdata = data_q[idx][off];

   assign cmp_write = cache_req.en & cache_req.comp & cache_req.write
                    & tag_match & valid_q[idx];
   assign install   = cache_req.en & ~cache_req.comp & cache_req.write;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < NUM_LINES; i++) begin
            valid_q[i] <= 1'b0;
            dirty_q[i] <= 1'b0;
            tag_q[i]   <= '0;
         end
      end else if (install) begin
         // line stays invalid until the last word lands
         valid_q[idx] <= cache_req.valid_in;
         dirty_q[idx] <= 1'b0;
         tag_q[idx]   <= cache_req.tag;
      end else if (cmp_write) begin
         dirty_q[idx] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (install | cmp_write) begin
         data_q[idx][off] <= cache_req.wdata;
      end
   end

endmodule

/* rtl/cache_ctrl.sv */
`timescale 1ns/1ns
module cache_ctrl
   import cache_pkg::*;
(
   input  logic       clk,
   input  logic       arst_n,
   input  logic       rd,
   input  logic       wr,
   input  addr_t      addr,
   input  word_t      data_in,
   input  cache_rsp_t cache_rsp,
   input  logic       mem_stall,
   input  word_t      mem_rdata,
   output cache_req_t cache_req,
   output mem_req_t   mem_req,
   output logic       done,
   output logic       hit,
   output logic       err,
   output logic       stall
);

   ctrl_state_e state;
   ctrl_state_e next_state;
   logic        missed;       // access went through allocate
   logic        line_hit;
   logic        fetching;
   logic        installing;
   tag_t        cpu_tag;
   index_t      cpu_index;
   offset_t     cpu_offset;
   offset_t     wb_off;
   offset_t     fetch_off;
   offset_t     install_off;

   assign cpu_tag    = addr[ADDR_W-1 -: TAG_W];
   assign cpu_index  = addr[OFFSET_W+1 +: INDEX_W];
   assign cpu_offset = addr[1 +: OFFSET_W];

   assign line_hit = cache_rsp.hit & cache_rsp.valid;

   // word position follows the state encoding in each phase
   assign wb_off      = offset_t'(state - WB_0);
   assign fetch_off   = offset_t'(state - ALLOC0);
   assign install_off = offset_t'(state - ALLOC2);

   assign fetching   = state inside {ALLOC0, ALLOC1, ALLOC2, ALLOC3};
   assign installing = state inside {ALLOC2, ALLOC3, ALLOC4, COMMIT};

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state <= IDLE;
      end else begin
         state <= next_state;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         missed <= 1'b0;
      end else if (state == IDLE) begin
         missed <= 1'b0;
      end else if (next_state == ALLOC0) begin
         missed <= 1'b1;
      end
   end

   always_comb begin
      next_state = state;
      case (state)
         IDLE: begin
            if (rd | wr) begin
               if (addr[0]) begin
                  next_state = ERROR;   // byte address, not a word
               end else begin
                  next_state = rd ? COMPARE_READ : COMPARE_WRITE;
               end
            end
         end
         COMPARE_READ, COMPARE_WRITE: begin
            if (line_hit) begin
               next_state = IDLE;
            end else begin
               next_state = cache_rsp.dirty ? WB_0 : ALLOC0;
            end
         end
         WB_0:   next_state = mem_stall ? WB_0 : WB_1;
         WB_1:   next_state = mem_stall ? WB_1 : WB_2;
         WB_2:   next_state = mem_stall ? WB_2 : WB_3;
         WB_3:   next_state = mem_stall ? WB_3 : ALLOC0;
         ALLOC0: next_state = mem_stall ? ALLOC0 : ALLOC1;
         ALLOC1: next_state = mem_stall ? ALLOC1 : ALLOC2;
         ALLOC2: next_state = mem_stall ? ALLOC2 : ALLOC3;
         ALLOC3: next_state = mem_stall ? ALLOC3 : ALLOC4;
         ALLOC4: next_state = COMMIT;
         COMMIT: begin
            if (rd) begin
               next_state = RD_RETRY;
            end else if (wr) begin
               next_state = WR_RETRY;
            end else begin
               next_state = ERROR;   // request vanished mid-miss
            end
         end
         default: next_state = IDLE;  // retries and error
      endcase
   end

   always_comb begin
      cache_req.en       = 1'b1;
      cache_req.comp     = 1'b0;
      cache_req.write    = 1'b0;
      cache_req.valid_in = 1'b0;
      cache_req.index    = cpu_index;
      cache_req.tag      = cpu_tag;
      cache_req.offset   = cpu_offset;
      cache_req.wdata    = data_in;
      mem_req.rd         = 1'b0;
      mem_req.wr         = 1'b0;
      mem_req.addr       = {cpu_tag, cpu_index, cpu_offset, 1'b0};
      mem_req.wdata      = cache_rsp.rdata;

      case (state)
         IDLE: begin
            cache_req.en   = rd | wr;
            cache_req.comp = 1'b1;
         end
         COMPARE_READ, RD_RETRY: begin
            cache_req.comp = 1'b1;
         end
         COMPARE_WRITE, WR_RETRY: begin
            cache_req.comp  = 1'b1;
            cache_req.write = 1'b1;
         end
         WB_0, WB_1, WB_2, WB_3: begin
            // victim word out to its old address
            cache_req.offset = wb_off;
            mem_req.wr       = 1'b1;
            mem_req.addr     = {cache_rsp.tag, cpu_index, wb_off, 1'b0};
         end
         ERROR: begin
            cache_req.en = 1'b0;
         end
         default: begin
         end
      endcase

      if (fetching) begin
         mem_req.rd   = 1'b1;
         mem_req.addr = {cpu_tag, cpu_index, fetch_off, 1'b0};
      end
      if (installing) begin
         cache_req.write    = 1'b1;
         cache_req.offset   = install_off;
         cache_req.wdata    = mem_rdata;  // read issued two states back
         cache_req.valid_in = (state == COMMIT);
      end
   end

   always_comb begin
      case (state)
         COMPARE_READ, COMPARE_WRITE: done = line_hit;
         RD_RETRY, WR_RETRY:          done = 1'b1;
         default:                     done = 1'b0;
      endcase
   end

   assign hit   = done & ~missed;
   assign err   = (state == ERROR);
   assign stall = (state != IDLE);

endmodule

/* rtl/cache_system.sv */
`timescale 1ns/1ns
module cache_system
   import cache_pkg::*;
(
   input  logic  clk,
   input  logic  arst_n,
   input  logic  rd,
   input  logic  wr,
   input  addr_t addr,
   input  word_t data_in,
   output word_t data_out,
   output logic  done,
   output logic  hit,
   output logic  err,
   output logic  stall
);

   cache_req_t cache_req;
   cache_rsp_t cache_rsp;
   mem_req_t   mem_req;
   logic       mem_stall;
   word_t      mem_rdata;

   cache_ctrl u_ctrl (
      .clk       (clk),
      .arst_n    (arst_n),
      .rd        (rd),
      .wr        (wr),
      .addr      (addr),
      .data_in   (data_in),
      .cache_rsp (cache_rsp),
      .mem_stall (mem_stall),
      .mem_rdata (mem_rdata),
      .cache_req (cache_req),
      .mem_req   (mem_req),
      .done      (done),
      .hit       (hit),
      .err       (err),
      .stall     (stall)
   );

   cache_store u_store (
      .clk       (clk),
      .arst_n    (arst_n),
      .cache_req (cache_req),
      .cache_rsp (cache_rsp)
   );

   banked_mem u_mem (
      .clk       (clk),
      .arst_n    (arst_n),
      .mem_req   (mem_req),
      .mem_stall (mem_stall),
      .mem_rdata (mem_rdata)
   );

   assign data_out = cache_rsp.rdata;   // valid with done on a read

endmodule

/* sim/tb_cache_system.sv */
`timescale 1ns/1ns
module tb_cache_system
   import cache_pkg::*;
();

   localparam int REQ_CYCLES   = 12 + 3 + 8;  // dirty miss, widest gap, stall margin
   localparam int RESET_CYCLES = 3;
   localparam int MISS_MIN_LAT = 8;           // compare, alloc0..4, commit, retry

   logic  clk;
   logic  arst_n;
   logic  rd;
   logic  wr;
   addr_t addr;
   word_t data_in;
   word_t data_out;
   logic  done;
   logic  hit;
   logic  err;
   logic  stall;

   // golden records, one entry per request
   logic [7:0] op_q    [$];
   addr_t      addr_q  [$];
   word_t      wdata_q [$];
   word_t      rdata_q [$];
   logic       hit_q   [$];
   logic       err_q   [$];

   int err_cnt;
   int cycle_cnt;
   int cycle_limit;

   cache_system uut (
      .clk      (clk),
      .arst_n   (arst_n),
      .rd       (rd),
      .wr       (wr),
      .addr     (addr),
      .data_in  (data_in),
      .data_out (data_out),
      .done     (done),
      .hit      (hit),
      .err      (err),
      .stall    (stall)
   );

   initial clk = 1'b0;
   always #20 clk = ~clk;

   always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

   task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                              input string what);
      if (got !== expected) begin
         $display("FAILED at %0t ns: %s (got 0x%0h, expected 0x%0h)",
                  $time, what, got, expected);
         err_cnt++;
      end
   endtask

   // reads op, addr, wdata, rdata, hit, err per line, skipping # comments
   task automatic load_golden(output logic ok);
      int         fd;
      int         ch;
      int         rc;
      logic [7:0] op;
      addr_t      a;
      word_t      w;
      word_t      r;
      int         h;
      int         e;
      ok = 1'b0;
      fd = $fopen("sim/cache_system_golden.txt", "r");
      if (fd != 0) begin
         ok = 1'b1;
         ch = $fgetc(fd);
         while (ch != -1) begin
            if (ch == "#") begin
               while (ch != -1 && ch != 10) ch = $fgetc(fd);
            end else if (ch == "R" || ch == "W") begin
               op = ch[7:0];
               rc = $fscanf(fd, "%h %h %h %d %d", a, w, r, h, e);
               if (rc == 5) begin
                  op_q.push_back(op);
                  addr_q.push_back(a);
                  wdata_q.push_back(w);
                  rdata_q.push_back(r);
                  hit_q.push_back(h != 0);
                  err_q.push_back(e != 0);
               end else begin
                  ok = 1'b0;   // short or garbled line
               end
            end else if (ch != " " && ch != 9 && ch != 10 && ch != 13) begin
               ok = 1'b0;
            end
            ch = $fgetc(fd);
         end
         $fclose(fd);
      end
      if (op_q.size() == 0) ok = 1'b0;
   endtask

   // drive one request, wait for done or err, check the response
   task automatic run_request(input int n, output int lat);
      logic finished;
      logic is_read;
      is_read = (op_q[n] == "R");
      @(posedge clk);
      rd      <= is_read;
      wr      <= ~is_read;
      addr    <= addr_q[n];
      data_in <= wdata_q[n];
      @(negedge clk);
      check_value(stall, 1'b0, "stall before request accepted");
      lat = 0;
      finished = 1'b0;
      while (!finished) begin
         @(negedge clk);
         lat++;
         check_value(stall, 1'b1, "stall while access in progress");
         finished = done | err;
      end
      if (err_q[n]) begin
         check_value(err, 1'b1, "err on misaligned address");
         check_value(done, 1'b0, "done on misaligned address");
         check_value(lat, 1, "err latency");
      end else begin
         check_value(err, 1'b0, "err on aligned address");
         check_value(hit, hit_q[n], "hit flag");
         if (is_read) check_value(data_out, rdata_q[n], "read data");
         if (hit_q[n]) begin
            check_value(lat, 1, "hit latency");
         end else begin
            check_value(lat >= MISS_MIN_LAT, 1'b1, "miss finished too early");
         end
      end
   endtask

   initial begin
      int   gap;
      int   lat;
      int   errs_before;
      int   seed;
      int   pass_cnt;
      int   fail_cnt;
      logic load_ok;
      arst_n      = 1'b0;
      rd          = 1'b0;
      wr          = 1'b0;
      addr        = '0;
      data_in     = '0;
      err_cnt     = 0;
      cycle_cnt   = 0;
      cycle_limit = 0;
      pass_cnt    = 0;
      fail_cnt    = 0;
      seed        = 86755;
      gap         = $urandom(seed);
      load_golden(load_ok);
      if (!load_ok) begin
         $display("golden file missing, empty or malformed");
         $display("Simulation FAILED");
         $finish;
      end else begin
         cycle_limit = op_q.size() * REQ_CYCLES + RESET_CYCLES + 10;
         repeat (RESET_CYCLES) @(posedge clk);
         arst_n <= 1'b1;
         for (int i = 0; i < op_q.size(); i++) begin
            errs_before = err_cnt;
            run_request(i, lat);
            if (err_cnt == errs_before) begin
               pass_cnt++;
               $display("test %0d: %c 0x%h in %0d cycles, pass", i, op_q[i], addr_q[i], lat);
            end else begin
               fail_cnt++;
               $display("test %0d: %c 0x%h in %0d cycles, fail", i, op_q[i], addr_q[i], lat);
            end
            gap = $urandom % 4;
            if (gap > 0) begin
               @(posedge clk);
               rd <= 1'b0;
               wr <= 1'b0;
               repeat (gap - 1) @(posedge clk);
            end
         end
         @(posedge clk);
         rd <= 1'b0;
         wr <= 1'b0;
         repeat (2) @(posedge clk);
         $display("%0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
         if (err_cnt == 0 && fail_cnt == 0) begin
            $display("Simulation PASSED");
         end else begin
            $display("Simulation FAILED");
         end
         $finish;
      end
   end

   // stop a run that never sees done or err
   initial begin
      wait (cycle_limit != 0);
      while (cycle_cnt < cycle_limit) @(posedge clk);
      $display("timeout, run still busy after %0d cycles", cycle_cnt);
      $display("Simulation FAILED");
      $finish;
   end

endmodule

/* sim/cache_system_golden.txt */
# op addr wdata exp_rdata exp_hit exp_err (op R read, W write, values hex)
# memory word at byte address a starts as (a >> 1) ^ a5a5
R 0008 0000 a5a1 0 0
R 000c 0000 a5a3 1 0
W 000a 1234 0000 1 0
R 000a 0000 1234 1 0
W 1050 beef 0000 0 0
R 1050 0000 beef 1 0
R 1056 0000 ad8e 1 0
R 0808 0000 a1a1 0 0
R 080e 0000 a1a2 1 0
R 000a 0000 1234 0 0
R 000c 0000 a5a3 1 0
R 3050 0000 bd8d 0 0
R 1050 0000 beef 0 0
W 1053 dead 0000 0 1
R 1052 0000 ad8c 1 0
R 0001 0000 0000 0 1
R 0008 0000 a5a1 1 0
W 0008 5a5a 0000 1 0
W 2008 7777 0000 0 0
R 0008 0000 5a5a 0 0
R 2008 0000 7777 0 0
R 200a 0000 b5a0 1 0

/* src.f */
rtl/cache_pkg.sv
rtl/banked_mem.sv
rtl/cache_store.sv
rtl/cache_ctrl.sv
rtl/cache_system.sv
sim/tb_cache_system.sv
